// File: design/soc_ctrl_settings.svh
/* sizes, reset values and register offsets of the SoC control block */
`ifndef SOC_CTRL_SETTINGS_SVH
`define SOC_CTRL_SETTINGS_SVH

`define N_IO          64  // pad count
`define NBIT_PADCFG   6   // pull up/down, st, slew, drive strength
`define NBIT_PADMUX   2
`define IO_IDX_WIDTH  6
`define JTAG_REG_SIZE 8
`define NB_CORES      4
`define NB_CLUSTERS   1

`define FC_BOOT_RESET 32'h1A000080

`define REG_INFO               12'h000  // cores in 31:16, clusters in 15:0
`define REG_FCBOOT             12'h004
`define REG_FCFETCH            12'h008
`define REG_WCFGFUN            12'h060  // select pad and write its cfg/mux
`define REG_RCFGFUN            12'h064  // select pad for reading
`define REG_CLUSTER_CTRL       12'h070
`define REG_JTAGREG            12'h074
`define REG_CLUSTER_IRQ        12'h07C
`define REG_CLUSTER_BOOT_ADDR0 12'h080
`define REG_CLUSTER_BOOT_ADDR1 12'h084
`define REG_CORESTATUS         12'h0A0  // eoc in bit 31, status below
`define REG_CS_RO              12'h0C0
`define REG_BOOTSEL            12'h0C4

`define PADWIN_BASE_HI 2'b01  // addr 11:10 of the 0x400-0x7FC pad window
`define BAD_ADDR_DATA  32'hDEADBEEF
`define PAD_OOR_DATA   32'h0095BEEF
`endif

// File: design/soc_ctrl_pkg.sv
/* bus and register request types, pad word layouts and pad bank ops */
`include "soc_ctrl_settings.svh"

package soc_ctrl_pkg;

  typedef logic [11:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  typedef struct packed {
    logic      valid;
    logic      write;
    apb_addr_t addr;
    apb_data_t wdata;
  } reg_req_t;

  typedef struct packed {
    apb_data_t rdata;
    logic      err;
  } reg_rsp_t;

  typedef logic [`NBIT_PADCFG-1:0] pad_cfg_t;
  typedef logic [`NBIT_PADMUX-1:0] pad_mux_t;

  // layout of REG_WCFGFUN / REG_RCFGFUN
  typedef struct packed {
    logic [31-24-`NBIT_PADCFG:0]  rsv_hi;
    pad_cfg_t                     cfg;     // 24 and up
    logic [23-16-`NBIT_PADMUX:0]  rsv_mid;
    pad_mux_t                     mux;     // 16 and up
    logic [15-`IO_IDX_WIDTH:0]    rsv_lo;
    logic [`IO_IDX_WIDTH-1:0]     idx;
  } pad_sel_fmt_t;

  // layout of one word in the pad window
  typedef struct packed {
    logic [31-8-`NBIT_PADCFG:0] rsv_hi;
    pad_cfg_t                   cfg;  // 8 and up
    logic [7-`NBIT_PADMUX:0]    rsv_lo;
    pad_mux_t                   mux;
  } pad_win_fmt_t;

  typedef union packed {
    pad_sel_fmt_t sel;
    pad_win_fmt_t win;
  } pad_word_u;

  typedef enum logic [2:0] {NONE, SELECT, WRITE_SEL, WRITE_WIN, READ_WIN} pad_op_e;

  typedef struct packed {
    pad_op_e    op;
    logic [7:0] idx;   // window index, addr 9:2
    pad_word_u  word;
  } pad_req_t;

  typedef struct packed {
    logic rstn;
    logic fetch_enable;
    logic pow;
    logic byp;
  } cluster_ctrl_t;

endpackage

// File: design/apb_reg_fsm.sv
/* APB slave FSM, one register request per transfer, registered response */
`timescale 1ns/10ps

module apb_reg_fsm (
  input  logic                    HCLK,
  input  logic                    HRESETn,
  input  soc_ctrl_pkg::apb_addr_t paddr_i,
  input  soc_ctrl_pkg::apb_data_t pwdata_i,
  input  logic                    pwrite_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  output soc_ctrl_pkg::apb_data_t prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  output soc_ctrl_pkg::reg_req_t  req_o,
  input  soc_ctrl_pkg::reg_rsp_t  rsp_i
);

  typedef enum logic [1:0] {IDLE, READ, WRITE, WAIT} state_e;

  state_e state_q;
  logic   access;

  assign access = (state_q == READ) || (state_q == WRITE);

  // address and data are held by the master until pready
  always_comb begin
    req_o.valid = access;
    req_o.write = (state_q == WRITE);
    req_o.addr  = paddr_i;
    req_o.wdata = pwdata_i;
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q   <= IDLE;
      prdata_o  <= '0;
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (psel_i && penable_i) begin
            state_q <= pwrite_i ? WRITE : READ;
          end
        end

        READ, WRITE: begin
          pready_o  <= 1'b1;  // single cycle pulse
          pslverr_o <= rsp_i.err;
          if (state_q == READ) begin
            prdata_o <= rsp_i.rdata;
          end
          state_q <= WAIT;
        end

        // penable may still be high here, so no new access starts
        WAIT: begin
          pready_o  <= 1'b0;
          pslverr_o <= 1'b0;
          state_q   <= IDLE;
        end

        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// File: design/pad_cfg_bank.sv
/* pad cfg and mux storage with selected-pad pointer, both write layouts */
`timescale 1ns/10ps
`include "soc_ctrl_settings.svh"

module pad_cfg_bank (
  input  logic                                HCLK,
  input  logic                                HRESETn,
  input  soc_ctrl_pkg::pad_req_t              req_i,
  output logic [`IO_IDX_WIDTH-1:0]            sel_idx_o,
  output soc_ctrl_pkg::pad_cfg_t              sel_cfg_o,
  output soc_ctrl_pkg::pad_mux_t              sel_mux_o,
  output soc_ctrl_pkg::pad_cfg_t              win_cfg_o,
  output soc_ctrl_pkg::pad_mux_t              win_mux_o,
  output soc_ctrl_pkg::pad_cfg_t [`N_IO-1:0]  pad_cfg_o,
  output soc_ctrl_pkg::pad_mux_t [`N_IO-1:0]  pad_mux_o
);

  import soc_ctrl_pkg::*;

  logic [`IO_IDX_WIDTH-1:0] sel_q;
  logic [`IO_IDX_WIDTH-1:0] win_idx;
  logic [`IO_IDX_WIDTH-1:0] fmt_idx;
  logic                     win_in_range;

  assign win_idx      = req_i.idx[`IO_IDX_WIDTH-1:0];
  assign fmt_idx      = req_i.word.sel.idx;
  assign win_in_range = (req_i.idx < `N_IO);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      sel_q     <= '0;
      pad_cfg_o <= '1;  // all pads start with every cfg bit set
      pad_mux_o <= '0;
    end else begin
      case (req_i.op)
        SELECT: sel_q <= fmt_idx;
        WRITE_SEL: begin
          sel_q              <= fmt_idx;
          pad_cfg_o[fmt_idx] <= req_i.word.sel.cfg;
          pad_mux_o[fmt_idx] <= req_i.word.sel.mux;
        end
        WRITE_WIN: begin
          if (win_in_range) begin  // out of range writes dropped
            sel_q              <= win_idx;
            pad_cfg_o[win_idx] <= req_i.word.win.cfg;
            pad_mux_o[win_idx] <= req_i.word.win.mux;
          end
        end
        READ_WIN: begin
          if (win_in_range) begin
            sel_q <= win_idx;
          end
        end
        default: ;
      endcase
    end
  end

  assign sel_idx_o = sel_q;
  assign sel_cfg_o = pad_cfg_o[sel_q];
  assign sel_mux_o = pad_mux_o[sel_q];
  assign win_cfg_o = pad_cfg_o[win_idx];  // regfile masks out of range
  assign win_mux_o = pad_mux_o[win_idx];

endmodule

// File: design/soc_ctrl_regfile.sv
/* SoC control registers, address decode and read mux, jtag sync, bootsel */
`timescale 1ns/10ps
`include "soc_ctrl_settings.svh"

module soc_ctrl_regfile (
  input  logic                                HCLK,
  input  logic                                HRESETn,
  input  soc_ctrl_pkg::reg_req_t              req_i,
  output soc_ctrl_pkg::reg_rsp_t              rsp_o,
  input  logic                                bootsel_i,
  input  logic                                fc_fetch_en_valid_i,
  input  logic                                fc_fetch_en_i,
  input  logic [`JTAG_REG_SIZE-1:0]           soc_jtag_reg_i,
  output logic [`JTAG_REG_SIZE-1:0]           soc_jtag_reg_o,
  output logic [31:0]                         fc_bootaddr_o,
  output logic                                fc_fetchen_o,
  output soc_ctrl_pkg::cluster_ctrl_t         cluster_ctrl_o,
  output logic                                cluster_irq_o,
  output logic [63:0]                         cluster_boot_addr_o,
  output soc_ctrl_pkg::pad_cfg_t [`N_IO-1:0]  pad_cfg_o,
  output soc_ctrl_pkg::pad_mux_t [`N_IO-1:0]  pad_mux_o
);

  import soc_ctrl_pkg::*;

  logic [`JTAG_REG_SIZE-1:0] jtag_sync_q [2];
  logic                      bootsel_q;
  apb_data_t                 corestatus_q;
  logic                      wr_en;
  logic                      is_win;
  pad_req_t                  pad_req;
  pad_word_u                 rd_word;
  logic [`IO_IDX_WIDTH-1:0]  sel_idx;
  pad_cfg_t                  sel_cfg;
  pad_mux_t                  sel_mux;
  pad_cfg_t                  win_cfg;
  pad_mux_t                  win_mux;

  assign wr_en  = req_i.valid & req_i.write;
  assign is_win = (req_i.addr[11:10] == `PADWIN_BASE_HI);

  always_comb begin
    rsp_o       = '{rdata: '0, err: 1'b0};
    rd_word     = '0;
    pad_req.op  = NONE;
    pad_req.idx = req_i.addr[9:2];
    pad_req.word = req_i.wdata;
    if (is_win) begin
      pad_req.op = req_i.write ? WRITE_WIN : READ_WIN;
      rd_word.win.cfg = win_cfg;
      rd_word.win.mux = win_mux;
      rsp_o.rdata = (pad_req.idx < `N_IO) ? rd_word : `PAD_OOR_DATA;
    end else begin
      rd_word.sel.cfg = sel_cfg;  // both select registers read the pointed pad
      rd_word.sel.mux = sel_mux;
      rd_word.sel.idx = sel_idx;
      case (req_i.addr)
        `REG_INFO:    rsp_o.rdata = {16'(`NB_CORES), 16'(`NB_CLUSTERS)};
        `REG_FCBOOT:  rsp_o.rdata = fc_bootaddr_o;
        `REG_FCFETCH: rsp_o.rdata = {31'h0, fc_fetchen_o};
        `REG_WCFGFUN: begin
          pad_req.op  = WRITE_SEL;
          rsp_o.rdata = rd_word;
        end
        `REG_RCFGFUN: begin
          pad_req.op  = SELECT;
          rsp_o.rdata = rd_word;
        end
        `REG_CLUSTER_CTRL: rsp_o.rdata = {28'h0, cluster_ctrl_o};
        `REG_JTAGREG: begin
          rsp_o.rdata = {{(32 - 2 * `JTAG_REG_SIZE){1'b0}}, jtag_sync_q[1], soc_jtag_reg_o};
        end
        `REG_CLUSTER_IRQ:        rsp_o.rdata = {31'h0, cluster_irq_o};
        `REG_CLUSTER_BOOT_ADDR0: rsp_o.rdata = cluster_boot_addr_o[31:0];
        `REG_CLUSTER_BOOT_ADDR1: rsp_o.rdata = cluster_boot_addr_o[63:32];
        `REG_CORESTATUS:         rsp_o.rdata = corestatus_q;
        `REG_CS_RO:              rsp_o.rdata = corestatus_q;
        `REG_BOOTSEL:            rsp_o.rdata = {31'h0, bootsel_q};
        default: begin
          rsp_o.rdata = `BAD_ADDR_DATA;
          rsp_o.err   = 1'b1;
        end
      endcase
      // read-only registers refuse writes
      if (req_i.write && (req_i.addr == `REG_INFO || req_i.addr == `REG_CS_RO ||
                          req_i.addr == `REG_BOOTSEL)) begin
        rsp_o.err = 1'b1;
      end
    end
    if (!req_i.valid || (!req_i.write && pad_req.op != READ_WIN && pad_req.op != NONE)) begin
      pad_req.op = NONE;  // select ops only move on writes
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      jtag_sync_q[0]      <= '0;
      jtag_sync_q[1]      <= '0;
      soc_jtag_reg_o      <= '0;
      fc_bootaddr_o       <= `FC_BOOT_RESET;
      fc_fetchen_o        <= 1'b0;  // fc idle until enabled
      cluster_ctrl_o      <= '{rstn: 1'b1, fetch_enable: 1'b0, pow: 1'b0, byp: 1'b1};
      cluster_irq_o       <= 1'b0;
      cluster_boot_addr_o <= '0;
      corestatus_q        <= '0;
    end else begin
      jtag_sync_q[0] <= soc_jtag_reg_i;
      jtag_sync_q[1] <= jtag_sync_q[0];
      if (wr_en && !is_win) begin
        case (req_i.addr)
          `REG_FCBOOT:             fc_bootaddr_o <= req_i.wdata;
          `REG_FCFETCH:            fc_fetchen_o <= req_i.wdata[0];
          `REG_CLUSTER_CTRL:       cluster_ctrl_o <= cluster_ctrl_t'(req_i.wdata[3:0]);
          `REG_JTAGREG:            soc_jtag_reg_o <= req_i.wdata[`JTAG_REG_SIZE-1:0];
          `REG_CLUSTER_IRQ:        cluster_irq_o <= req_i.wdata[0];
          `REG_CLUSTER_BOOT_ADDR0: cluster_boot_addr_o[31:0] <= req_i.wdata;
          `REG_CLUSTER_BOOT_ADDR1: cluster_boot_addr_o[63:32] <= req_i.wdata;
          `REG_CORESTATUS:         corestatus_q <= req_i.wdata;
          default: ;
        endcase
      end
      if (fc_fetch_en_valid_i) begin
        fc_fetchen_o <= fc_fetch_en_i;  // external pair wins over the bus
      end
    end
  end

  // boot select follows the pin while in reset, then holds
  always_ff @(posedge HCLK) begin
    if (!HRESETn) begin
      bootsel_q <= bootsel_i;
    end
  end

  pad_cfg_bank i_pad_bank (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .req_i     (pad_req),
    .sel_idx_o (sel_idx),
    .sel_cfg_o (sel_cfg),
    .sel_mux_o (sel_mux),
    .win_cfg_o (win_cfg),
    .win_mux_o (win_mux),
    .pad_cfg_o (pad_cfg_o),
    .pad_mux_o (pad_mux_o)
  );

endmodule

// File: design/soc_ctrl_top.sv
/* SoC control block top, APB FSM plus register file */
`timescale 1ns/10ps
`include "soc_ctrl_settings.svh"

module soc_ctrl_top (
  input  logic                                HCLK,
  input  logic                                HRESETn,
  input  soc_ctrl_pkg::apb_addr_t             paddr_i,
  input  soc_ctrl_pkg::apb_data_t             pwdata_i,
  input  logic                                pwrite_i,
  input  logic                                psel_i,
  input  logic                                penable_i,
  output soc_ctrl_pkg::apb_data_t             prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o,
  input  logic                                bootsel_i,
  input  logic                                fc_fetch_en_valid_i,
  input  logic                                fc_fetch_en_i,
  input  logic [`JTAG_REG_SIZE-1:0]           soc_jtag_reg_i,
  output logic [`JTAG_REG_SIZE-1:0]           soc_jtag_reg_o,
  output logic [31:0]                         fc_bootaddr_o,
  output logic                                fc_fetchen_o,
  output logic                                cluster_pow_o,
  output logic                                cluster_byp_o,
  output logic                                cluster_fetch_enable_o,
  output logic                                cluster_rstn_o,
  output logic                                cluster_irq_o,
  output logic [63:0]                         cluster_boot_addr_o,
  output soc_ctrl_pkg::pad_cfg_t [`N_IO-1:0]  pad_cfg_o,
  output soc_ctrl_pkg::pad_mux_t [`N_IO-1:0]  pad_mux_o
);

  import soc_ctrl_pkg::*;

  reg_req_t      req;
  reg_rsp_t      rsp;
  cluster_ctrl_t cluster_ctrl;

  apb_reg_fsm i_apb_fsm (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .pwrite_i  (pwrite_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .req_o     (req),
    .rsp_i     (rsp)
  );

  soc_ctrl_regfile i_regfile (
    .HCLK                (HCLK),
    .HRESETn             (HRESETn),
    .req_i               (req),
    .rsp_o               (rsp),
    .bootsel_i           (bootsel_i),
    .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
    .fc_fetch_en_i       (fc_fetch_en_i),
    .soc_jtag_reg_i      (soc_jtag_reg_i),
    .soc_jtag_reg_o      (soc_jtag_reg_o),
    .fc_bootaddr_o       (fc_bootaddr_o),
    .fc_fetchen_o        (fc_fetchen_o),
    .cluster_ctrl_o      (cluster_ctrl),
    .cluster_irq_o       (cluster_irq_o),
    .cluster_boot_addr_o (cluster_boot_addr_o),
    .pad_cfg_o           (pad_cfg_o),
    .pad_mux_o           (pad_mux_o)
  );

  // cluster control bits out to the cluster
  assign cluster_rstn_o         = cluster_ctrl.rstn;
  assign cluster_fetch_enable_o = cluster_ctrl.fetch_enable;
  assign cluster_pow_o          = cluster_ctrl.pow;
  assign cluster_byp_o          = cluster_ctrl.byp;

endmodule

// File: testbench/soc_ctrl_assertions.sv
/* APB protocol assertions, bound to the SoC control top */
`timescale 1ns/10ps

module soc_ctrl_assertions (
  input logic HCLK,
  input logic HRESETn,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic pslverr_i
);

  property ready_single_pulse;
    @(posedge HCLK) disable iff (!HRESETn) pready_i |=> !pready_i;
  endproperty

  property err_with_ready;
    @(posedge HCLK) disable iff (!HRESETn) pslverr_i |-> pready_i;
  endproperty

  // access held over the two edges before pready
  property ready_after_access;
    @(posedge HCLK) disable iff (!HRESETn)
      $rose(pready_i) |-> $past(psel_i && penable_i, 2) && $past(psel_i && penable_i, 1);
  endproperty

  property ready_low_in_reset;
    @(posedge HCLK) !HRESETn |-> !pready_i;
  endproperty

  a_ready_pulse: assert property (ready_single_pulse)
    else $error("pready high on two consecutive cycles");
  a_err_ready: assert property (err_with_ready)
    else $error("pslverr high without pready");
  a_ready_timing: assert property (ready_after_access)
    else $error("pready rose without a sampled access two edges before");
  a_reset: assert property (ready_low_in_reset)
    else $error("pready high during reset");

endmodule

bind soc_ctrl_top soc_ctrl_assertions u_apb_checks (
  .HCLK      (HCLK),
  .HRESETn   (HRESETn),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pready_i  (pready_o),
  .pslverr_i (pslverr_o)
);

// File: testbench/soc_ctrl_tb.sv
/* testbench for the SoC control block: clock, reset, APB driver,
   stimulus table, compare tasks and timeout */
`timescale 1ns/10ps
`include "soc_ctrl_settings.svh"

module soc_ctrl_tb;

  import soc_ctrl_pkg::*;

  typedef enum int {PORTS_NONE, PORTS_FCBOOT, PORTS_CLUSTER, PORTS_IRQ, PORTS_BOOT_ADDR,
                    PORTS_PAD, PORTS_JTAG} port_check_e;

  typedef struct {
    bit          write;
    apb_addr_t   addr;
    apb_data_t   wdata;
    apb_data_t   exp_rdata;
    bit          exp_err;
    port_check_e check_ports;
  } stim_row_t;

  localparam logic [7:0] JTAG_IN = 8'hC3;

  logic                      HCLK;
  logic                      HRESETn;
  apb_addr_t                 paddr_i;
  apb_data_t                 pwdata_i;
  logic                      pwrite_i, psel_i, penable_i;
  apb_data_t                 prdata_o;
  logic                      pready_o, pslverr_o;
  logic                      bootsel_i, fc_fetch_en_valid_i, fc_fetch_en_i;
  logic [7:0]                soc_jtag_reg_i, soc_jtag_reg_o;
  logic [31:0]               fc_bootaddr_o;
  logic                      fc_fetchen_o, cluster_pow_o, cluster_byp_o;
  logic                      cluster_fetch_enable_o, cluster_rstn_o, cluster_irq_o;
  logic [63:0]               cluster_boot_addr_o;
  pad_cfg_t [`N_IO-1:0]      pad_cfg_o;
  pad_mux_t [`N_IO-1:0]      pad_mux_o;

  stim_row_t   rows[$];
  logic [31:0] lfsr_q = 32'h3cb2;
  int          cycle_count = 0;
  int          timeout_limit = 0;
  int          error_count = 0;

  soc_ctrl_top UUT (.*);

  initial begin
    HCLK = 1'b0;
    forever #4 HCLK = ~HCLK;
  end

  task automatic fail_run(input string line);
    error_count++;
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_data(input apb_data_t got, input apb_data_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s got %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_err(input bit got, input bit exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s got %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_cluster(input cluster_ctrl_t got, input cluster_ctrl_t exp,
                               input string what);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s got %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_pad(input pad_cfg_t got_cfg, input pad_mux_t got_mux,
                           input pad_cfg_t exp_cfg, input pad_mux_t exp_mux, input string what);
    if (got_cfg !== exp_cfg || got_mux !== exp_mux) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s got cfg %h mux %h, expected cfg %h mux %h",
                         $time, what, got_cfg, got_mux, exp_cfg, exp_mux));
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // pad-select word: cfg at 24, mux at 16, index at 0
  function automatic apb_data_t sel_layout(input pad_cfg_t cfg, input pad_mux_t mux, input int idx);
    apb_data_t w;
    w = '0;
    w[24 +: `NBIT_PADCFG]  = cfg;
    w[16 +: `NBIT_PADMUX]  = mux;
    w[0 +: `IO_IDX_WIDTH]  = idx[`IO_IDX_WIDTH-1:0];
    return w;
  endfunction

  // window word: cfg at 8, mux at 0
  function automatic apb_data_t win_layout(input pad_cfg_t cfg, input pad_mux_t mux);
    apb_data_t w;
    w = '0;
    w[8 +: `NBIT_PADCFG] = cfg;
    w[0 +: `NBIT_PADMUX] = mux;
    return w;
  endfunction

  function automatic apb_addr_t win_addr(input int idx);
    return apb_addr_t'(32'h400 + idx * 4);
  endfunction

  function automatic void add_row(input bit write, input apb_addr_t addr, input apb_data_t wdata,
                                  input apb_data_t exp_rdata, input bit exp_err,
                                  input port_check_e check_ports);
    stim_row_t r;
    r.write       = write;
    r.addr        = addr;
    r.wdata       = wdata;
    r.exp_rdata   = exp_rdata;
    r.exp_err     = exp_err;
    r.check_ports = check_ports;
    rows.push_back(r);
  endfunction

  function automatic void build_table();
    add_row(0, `REG_INFO, 0, 32'h0004_0001, 0, PORTS_NONE);  // 4 cores, 1 cluster
    add_row(0, `REG_BOOTSEL, 0, 32'h1, 0, PORTS_NONE);
    add_row(0, `REG_FCBOOT, 0, 32'h1A00_0080, 0, PORTS_NONE);
    add_row(0, `REG_FCFETCH, 0, 32'h1, 0, PORTS_NONE);       // set by external pulse
    add_row(1, `REG_FCBOOT, 32'h1C00_8000, 0, 0, PORTS_FCBOOT);
    add_row(0, `REG_FCBOOT, 0, 32'h1C00_8000, 0, PORTS_NONE);
    add_row(1, `REG_CORESTATUS, 32'h8000_00A5, 0, 0, PORTS_NONE);
    add_row(0, `REG_CORESTATUS, 0, 32'h8000_00A5, 0, PORTS_NONE);
    add_row(0, `REG_CS_RO, 0, 32'h8000_00A5, 0, PORTS_NONE);
    add_row(1, `REG_CS_RO, 32'h1234_5678, 0, 1, PORTS_NONE);
    add_row(0, `REG_CORESTATUS, 0, 32'h8000_00A5, 0, PORTS_NONE);
    add_row(1, `REG_CLUSTER_CTRL, 32'h6, 0, 0, PORTS_CLUSTER);
    add_row(0, `REG_CLUSTER_CTRL, 0, 32'h6, 0, PORTS_NONE);
    add_row(1, `REG_CLUSTER_CTRL, 32'h9, 0, 0, PORTS_CLUSTER);
    add_row(1, `REG_CLUSTER_IRQ, 32'h1, 0, 0, PORTS_IRQ);
    add_row(0, `REG_CLUSTER_IRQ, 0, 32'h1, 0, PORTS_NONE);
    add_row(1, `REG_CLUSTER_BOOT_ADDR0, 32'h1C00_0100, 0, 0, PORTS_BOOT_ADDR);
    add_row(1, `REG_CLUSTER_BOOT_ADDR1, 32'h0000_00AB, 0, 0, PORTS_BOOT_ADDR);
    add_row(0, `REG_CLUSTER_BOOT_ADDR0, 0, 32'h1C00_0100, 0, PORTS_NONE);
    add_row(0, `REG_CLUSTER_BOOT_ADDR1, 0, 32'h0000_00AB, 0, PORTS_NONE);
    add_row(1, `REG_WCFGFUN, sel_layout(6'h15, 2'h2, 5), 0, 0, PORTS_PAD);
    add_row(0, win_addr(5), 0, win_layout(6'h15, 2'h2), 0, PORTS_NONE);
    add_row(1, win_addr(9), win_layout(6'h2A, 2'h1), 0, 0, PORTS_PAD);
    add_row(0, win_addr(5), 0, win_layout(6'h15, 2'h2), 0, PORTS_NONE);  // pointer back to 5
    add_row(1, `REG_RCFGFUN, 32'd9, 0, 0, PORTS_NONE);
    add_row(0, `REG_RCFGFUN, 0, sel_layout(6'h2A, 2'h1, 9), 0, PORTS_NONE);
    add_row(0, win_addr(70), 0, `PAD_OOR_DATA, 0, PORTS_NONE);
    add_row(0, 12'h010, 0, `BAD_ADDR_DATA, 1, PORTS_NONE);
    add_row(1, `REG_JTAGREG, 32'h5A, 0, 0, PORTS_JTAG);
    add_row(0, `REG_JTAGREG, 0, {16'h0, JTAG_IN, 8'h5A}, 0, PORTS_NONE);
  endfunction

  // one APB transfer after a random idle gap, called and returning on a falling edge
  task automatic apb_transfer(input stim_row_t r, output apb_data_t rdata, output bit err);
    logic [2:0] gap;
    int         b;
    gap = '0;
    for (b = 0; b < 3; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      gap    = {gap[1:0], lfsr_q[0]};
    end
    repeat (gap) @(negedge HCLK);
    psel_i   = 1'b1;
    pwrite_i = r.write;
    paddr_i  = r.addr;
    pwdata_i = r.wdata;
    @(negedge HCLK);
    penable_i = 1'b1;
    do @(negedge HCLK); while (pready_o !== 1'b1);
    rdata     = prdata_o;
    err       = pslverr_o;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic check_row_ports(input stim_row_t r, input int n);
    cluster_ctrl_t exp_cl;
    cluster_ctrl_t got_cl;
    int            idx;
    string         what;
    what = $sformatf("row %0d ports", n);
    case (r.check_ports)
      PORTS_FCBOOT: check_data(fc_bootaddr_o, r.wdata, what);
      PORTS_CLUSTER: begin
        exp_cl.rstn         = r.wdata[3];
        exp_cl.fetch_enable = r.wdata[2];
        exp_cl.pow          = r.wdata[1];
        exp_cl.byp          = r.wdata[0];
        got_cl.rstn         = cluster_rstn_o;
        got_cl.fetch_enable = cluster_fetch_enable_o;
        got_cl.pow          = cluster_pow_o;
        got_cl.byp          = cluster_byp_o;
        check_cluster(got_cl, exp_cl, what);
      end
      PORTS_IRQ: check_data({31'h0, cluster_irq_o}, {31'h0, r.wdata[0]}, what);
      PORTS_BOOT_ADDR: begin
        if (r.addr == `REG_CLUSTER_BOOT_ADDR0) begin
          check_data(cluster_boot_addr_o[31:0], r.wdata, what);
        end else begin
          check_data(cluster_boot_addr_o[63:32], r.wdata, what);
        end
      end
      PORTS_PAD: begin
        if (r.addr == `REG_WCFGFUN) begin
          idx = int'(r.wdata[0 +: `IO_IDX_WIDTH]);
          check_pad(pad_cfg_o[idx], pad_mux_o[idx], r.wdata[24 +: `NBIT_PADCFG],
                    r.wdata[16 +: `NBIT_PADMUX], what);
        end else begin
          idx = int'(r.addr[9:2]);  // window slot
          check_pad(pad_cfg_o[idx], pad_mux_o[idx], r.wdata[8 +: `NBIT_PADCFG],
                    r.wdata[0 +: `NBIT_PADMUX], what);
        end
      end
      PORTS_JTAG: check_data({24'h0, soc_jtag_reg_o}, {24'h0, r.wdata[7:0]}, what);
      default: ;
    endcase
  endtask

  task automatic check_reset_ports();
    int p;
    check_data({31'h0, pready_o}, 32'h0, "pready_o after reset");
    check_err(pslverr_o, 1'b0, "pslverr_o after reset");
    check_data(prdata_o, 32'h0, "prdata_o after reset");
    check_data(fc_bootaddr_o, 32'h1A00_0080, "fc_bootaddr_o after reset");
    check_data({30'h0, fc_fetchen_o, cluster_irq_o}, 32'h0, "fetch enable and irq after reset");
    check_cluster({cluster_rstn_o, cluster_fetch_enable_o, cluster_pow_o, cluster_byp_o},
                  4'b1001, "cluster control after reset");
    for (p = 0; p < `N_IO; p++) begin
      check_pad(pad_cfg_o[p], pad_mux_o[p], '1, '0, $sformatf("pad %0d after reset", p));
    end
  endtask

  always @(posedge HCLK) begin
    cycle_count++;
    if (cycle_count > timeout_limit) begin
      fail_run($sformatf("Timeout: the run did not finish within %0d cycles", timeout_limit));
    end
  end

  initial begin
    apb_data_t rdata;
    bit        err;
    build_table();
    timeout_limit       = rows.size() * 11 + 8 + 50;
    HRESETn             = 1'b0;
    paddr_i             = '0;
    pwdata_i            = '0;
    pwrite_i            = 1'b0;
    psel_i              = 1'b0;
    penable_i           = 1'b0;
    bootsel_i           = 1'b1;  // sampled while in reset
    fc_fetch_en_valid_i = 1'b0;
    fc_fetch_en_i       = 1'b0;
    soc_jtag_reg_i      = '0;
    repeat (8) @(negedge HCLK);
    HRESETn   = 1'b1;
    bootsel_i = 1'b0;
    check_reset_ports();
    soc_jtag_reg_i      = JTAG_IN;
    fc_fetch_en_valid_i = 1'b1;
    fc_fetch_en_i       = 1'b1;
    @(negedge HCLK);
    fc_fetch_en_valid_i = 1'b0;
    fc_fetch_en_i       = 1'b0;
    check_data({31'h0, fc_fetchen_o}, 32'h1, "fc_fetchen_o after external pulse");
    foreach (rows[i]) begin
      apb_transfer(rows[i], rdata, err);
      check_err(err, rows[i].exp_err, $sformatf("row %0d pslverr", i));
      if (!rows[i].write) begin
        check_data(rdata, rows[i].exp_rdata, $sformatf("row %0d prdata", i));
      end
      check_row_ports(rows[i], i);
    end
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+design
design/soc_ctrl_pkg.sv
design/apb_reg_fsm.sv
design/pad_cfg_bank.sv
design/soc_ctrl_regfile.sv
design/soc_ctrl_top.sv
testbench/soc_ctrl_assertions.sv
testbench/soc_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the SoC control testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module soc_ctrl_tb \
  -f files.f -o soc_ctrl_sim > build.log 2>&1 \
  && ./obj_dir/soc_ctrl_sim > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }
grep -q "All tests passed" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; cat sim.log; exit 1; }
